// File: build.f
+incdir+dv
hdl/reset_seq_pkg.sv
hdl/reset_step.sv
hdl/reset_chain.sv
hdl/reset_regs.sv
hdl/reset_seq_top.sv
dv/reset_seq_tb.sv

// File: dv/reset_seq_wb_tasks.svh
`ifndef RESET_SEQ_WB_TASKS_SVH
`define RESET_SEQ_WB_TASKS_SVH

// one classic cycle, strobe raised on a falling edge and held until ack
task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdata,
		output wb_data_t rdata, output int req_cyc);
	int waited;
	@(negedge hw);
	wb_cyc   = 1'b1;
	wb_stb   = 1'b1;
	wb_we    = we;
	wb_adr   = adr;
	wb_wdata = wdata;
	req_cyc  = cyc;
	if (we) begin
		note_write(adr, wdata);  // model takes it on the ack edge
	end
	waited = 0;
	do begin
		@(negedge hw);
		waited++;
	end while (wb_ack !== 1'b1 && waited < ACK_WAIT);
	if (wb_ack !== 1'b1) begin
		errors++;
		$display("Error at %0t: no ack for the bus cycle to address %0d", $time, adr);
	end else if (waited != 1) begin
		report_mismatch($sformatf("ack %0d cycles after strobe, expected 1", waited));
	end
	rdata  = wb_rdata;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we  = 1'b0;
endtask

task automatic write_reg(input wb_addr_t adr, input wb_data_t data);
	wb_data_t unused_rdata;
	int       unused_cyc;
	bus_cycle(1'b1, adr, data, unused_rdata, unused_cyc);
endtask

// every falling edge: ack only one edge after a fresh strobe, never on its own
function automatic void check_ack_timing();
	logic exp_ack;
	exp_ack = stb_q && !ack_prev;
	if (wb_ack !== exp_ack) begin
		report_mismatch($sformatf("wb_ack is %b, expected %b", wb_ack, exp_ack));
	end
	ack_prev = wb_ack;
endfunction

`endif

// File: dv/reset_seq_tb.sv
`timescale 1ns/1ns

module reset_seq_tb;
	import reset_seq_pkg::*;

	localparam int NSTEP    = 4;
	localparam int NROUND   = 16;
	localparam int MAX_LEN  = 40;
	localparam int POR_LEN  = 20;  // hold length out of power-on
	localparam int ACK_WAIT = 4;
	// four times the worst case, every chain at full length plus bus traffic
	localparam int CYCLE_LIMIT = 4 * ((NROUND + 2) * NSTEP * (MAX_LEN + 16) + NROUND * 100);

	logic             hw = 1'b0;
	logic             poweronreset;
	logic             wb_cyc;
	logic             wb_stb;
	logic             wb_we;
	wb_addr_t         wb_adr;
	wb_data_t         wb_wdata;
	wb_data_t         wb_rdata;
	logic             wb_ack;
	logic [NSTEP-1:0] step_ready;
	logic [NSTEP-1:0] step_reset;

	int               cyc = 0;       // rising edges so far
	int               errors = 0;
	logic             por_q = 1'b1;  // inputs as sampled on the last rising edge
	logic             stb_q = 1'b0;
	logic             ack_prev = 1'b0;

	// reference model, as seen on each falling edge
	logic [NSTEP-1:0] exp_done = '0;
	logic [NSTEP-1:0] prev_reset = '0;
	logic [NSTEP-1:0] waiting = '0;    // reset released, block not ready yet
	logic [NSTEP-1:0] done_hist [64];  // done vector per cycle, for status reads
	int               hold_run [NSTEP];
	int               exp_len [NSTEP];
	int               expect_rise [NSTEP];
	int               done_set_cyc [NSTEP];
	int               ready_delay [NSTEP];
	step_len_t        model_len = step_len_t'(POR_LEN);
	step_len_t        pending_len = step_len_t'(POR_LEN);
	int               len_eff_cyc = -1;
	int               restart_q [$];   // cycles at which a restart shows on step_reset

	reset_seq_top #(
		.NSTEP (NSTEP)
	) u_reset_seq_top (
		.hw           (hw),
		.poweronreset (poweronreset),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_wdata     (wb_wdata),
		.wb_rdata     (wb_rdata),
		.wb_ack       (wb_ack),
		.step_ready   (step_ready),
		.step_reset   (step_reset)
	);

	always #2 hw = ~hw;

	function automatic void report_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t: %s", $time, msg);
	endfunction

	function automatic void note_write(input wb_addr_t adr, input wb_data_t data);
		if (adr == REG_LEN) begin
			pending_len = step_len_t'(data);
			len_eff_cyc = cyc + 1;  // hold_len moves on the ack edge
		end
		if (adr == REG_CTRL && data[CTRL_RESTART_BIT]) begin
			restart_q.push_back(cyc + 2);  // chain_start first, then step 0 holds
		end
	endfunction

	`include "reset_seq_wb_tasks.svh"

	// hold length and ordering checks for one step, then its block model
	function automatic void track_step(input int k, input logic restarting);
		logic rst;
		rst = step_reset[k];
		if (restarting) begin
			if (rst !== (k == 0)) begin
				report_mismatch($sformatf("step %0d reset is %b after restart", k, rst));
			end
			hold_run[k] = (k == 0) ? 1 : 0;
			exp_len[k]  = int'(model_len);
			waiting[k]  = 1'b0;
		end else if (rst && !prev_reset[k]) begin
			if (cyc != expect_rise[k]) begin
				report_mismatch($sformatf("step %0d reset rose at cycle %0d, expected %0d",
					k, cyc, expect_rise[k]));
			end
			hold_run[k] = 1;
			exp_len[k]  = int'(model_len);  // value loaded on the start edge
		end else if (rst) begin
			hold_run[k]++;
		end else if (prev_reset[k]) begin
			if (hold_run[k] != exp_len[k]) begin
				report_mismatch($sformatf("step %0d reset high %0d cycles, expected %0d",
					k, hold_run[k], exp_len[k]));
			end
			waiting[k]     = 1'b1;
			ready_delay[k] = $urandom % 16;
		end else if (cyc == expect_rise[k]) begin
			report_mismatch($sformatf("step %0d reset did not rise at cycle %0d", k, cyc));
		end
		if (rst) begin
			step_ready[k] = 1'b0;  // block held in reset
		end else if (waiting[k]) begin
			if (ready_delay[k] == 0) begin
				step_ready[k]   = 1'b1;
				waiting[k]      = 1'b0;
				done_set_cyc[k] = cyc + 1;
				if (k < NSTEP - 1) begin
					expect_rise[k+1] = cyc + 2;  // done strobe, then next step holds
				end
			end else begin
				ready_delay[k]--;
			end
		end
	endfunction

	always @(posedge hw) begin
		cyc++;
		por_q = poweronreset;
		stb_q = wb_cyc && wb_stb;
		if (cyc >= CYCLE_LIMIT) begin
			$display("Timeout: no result after %0d cycles", cyc);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	always @(negedge hw) begin
		logic restarting;
		restarting = 1'b0;
		check_ack_timing();
		if (por_q) begin
			if (step_reset !== '0) begin
				report_mismatch("step_reset high during poweronreset");
			end
		end else begin
			if (restart_q.size() > 0 && restart_q[0] == cyc) begin
				restarting = 1'b1;
				void'(restart_q.pop_front());
			end
			for (int k = 0; k < NSTEP; k++) begin
				if (done_set_cyc[k] == cyc) begin
					exp_done[k] = 1'b1;
				end
			end
			if (restarting) begin
				exp_done = '0;  // a late done strobe loses against the restart
				for (int k = 0; k < NSTEP; k++) begin
					done_set_cyc[k] = -1;
					expect_rise[k]  = -1;
				end
			end
			for (int k = 0; k < NSTEP; k++) begin
				track_step(k, restarting);
			end
			if (cyc == len_eff_cyc) begin
				model_len = pending_len;
			end
		end
		done_hist[cyc % 64] = exp_done;
		prev_reset = step_reset;
	end

	task automatic wait_chain_done();
		repeat (2) @(posedge hw);  // let a fresh restart clear the model first
		while (exp_done !== {NSTEP{1'b1}}) begin
			@(posedge hw);
		end
	endtask

	task automatic read_status_expect();
		wb_data_t rdata;
		int       req_cyc;
		bus_cycle(1'b0, REG_STATUS, '0, rdata, req_cyc);
		if (rdata !== wb_data_t'(done_hist[req_cyc % 64])) begin
			report_mismatch($sformatf("status read %h, model done vector %h",
				rdata, done_hist[req_cyc % 64]));
		end
	endtask

	task automatic read_reg_expect(input wb_addr_t adr, input wb_data_t exp_word);
		wb_data_t rdata;
		int       req_cyc;
		bus_cycle(1'b0, adr, '0, rdata, req_cyc);
		if (rdata !== exp_word) begin
			report_mismatch($sformatf("read of address %0d gave %h, expected %h",
				adr, rdata, exp_word));
		end
	endtask

	initial begin
		step_len_t len;
		wb_data_t  ctrl_word;
		void'($urandom(32'h8c58));
		poweronreset = 1'b1;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_wdata     = '0;
		step_ready   = '0;
		for (int k = 0; k < NSTEP; k++) begin
			hold_run[k]     = 0;
			exp_len[k]      = 0;
			expect_rise[k]  = -1;
			done_set_cyc[k] = -1;
			ready_delay[k]  = 0;
		end
		repeat (2) @(negedge hw);
		poweronreset = 1'b0;
		restart_q.push_back(cyc + 2);  // chain runs by itself after release
		wait_chain_done();
		read_status_expect();
		read_reg_expect(REG_LEN, wb_data_t'(POR_LEN));
		for (int round = 0; round < NROUND; round++) begin
			len = step_len_t'(1 + $urandom % MAX_LEN);
			write_reg(REG_LEN, wb_data_t'(len));
			read_reg_expect(REG_LEN, wb_data_t'(len));
			if ($urandom % 3 == 0) begin
				ctrl_word = wb_data_t'($urandom) & ~wb_data_t'(1);
				write_reg(REG_CTRL, ctrl_word);  // restart bit clear
			end
			write_reg(REG_CTRL, wb_data_t'(1));
			read_status_expect();
			if ($urandom % 3 == 0) begin
				repeat (5 + $urandom % 60) @(negedge hw);
				read_status_expect();  // next restart lands mid chain
			end else begin
				wait_chain_done();
				read_status_expect();
			end
			read_reg_expect(2'd3, '0);
		end
		write_reg(REG_CTRL, wb_data_t'(1));
		wait_chain_done();
		read_status_expect();
		$display("%0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: hdl/reset_chain.sv
`timescale 1ns/1ns

module reset_chain #(
	parameter int NSTEP = 4
) (
	input  logic                     hw,
	input  logic                     poweronreset,
	input  logic                     chain_start,
	input  reset_seq_pkg::step_len_t hold_len,
	input  logic [NSTEP-1:0]         step_ready,
	output logic [NSTEP-1:0]         step_reset,
	output logic [NSTEP-1:0]         step_done
);

	logic [NSTEP-1:0] done_strobe;  // per step, one cycle after its ready
	logic [NSTEP-1:0] step_start;
	logic [NSTEP-1:0] step_clear;   // sync clear into each step

	genvar k;
	generate
		for (k = 0; k < NSTEP; k++) begin : g_step
			if (k == 0) begin : g_first
				// head of the chain, (re)started from the register block
				assign step_start[k] = chain_start;
				assign step_clear[k] = poweronreset;
			end else begin : g_next
				assign step_start[k] = done_strobe[k-1];
				// restart drops every later step back to idle
				assign step_clear[k] = poweronreset | chain_start;
			end

			reset_step u_step (
				.hw           (hw),
				.poweronreset (step_clear[k]),
				.start        (step_start[k]),
				.hold_len     (hold_len),
				.ready        (step_ready[k]),
				.block_reset  (step_reset[k]),
				.done         (step_done[k]),
				.done_strobe  (done_strobe[k])
			);
		end
	endgenerate

endmodule

// File: hdl/reset_regs.sv
`timescale 1ns/1ns

module reset_regs #(
	parameter int NSTEP = 4
) (
	input  logic                     hw,
	input  logic                     poweronreset,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  reset_seq_pkg::wb_addr_t  wb_adr,
	input  reset_seq_pkg::wb_data_t  wb_wdata,
	output reset_seq_pkg::wb_data_t  wb_rdata,
	output logic                     wb_ack,
	input  logic [NSTEP-1:0]         step_done,
	output logic                     chain_start,
	output reset_seq_pkg::step_len_t hold_len
);
	import reset_seq_pkg::*;

	logic     bus_access;   // classic cycle waiting for its ack
	logic     bus_write;
	logic     bus_read;
	logic     restart_wr;
	logic     por_pending;  // set through power-on, fires the first start
	wb_data_t rd_mux;

	// ack goes back low for a cycle, so one strobe never gets two acks
	assign bus_access = wb_cyc && wb_stb && !wb_ack;
	assign bus_write  = bus_access && wb_we;
	assign bus_read   = bus_access && !wb_we;
	assign restart_wr = bus_write && (wb_adr == REG_CTRL) && wb_wdata[CTRL_RESTART_BIT];

	always_comb begin
		rd_mux = '0;
		case (wb_adr)
			REG_LEN: begin
				rd_mux = wb_data_t'(hold_len);
			end
			REG_STATUS: begin
				rd_mux = wb_data_t'(step_done);  // zero above NSTEP
			end
			default: begin
				rd_mux = '0;  // ctrl and unmapped read as zero
			end
		endcase
	end

	// bus handshake, control strobe and the length register
	always_ff @(posedge hw) begin
		if (poweronreset) begin
			wb_ack      <= 1'b0;
			chain_start <= 1'b0;
			por_pending <= 1'b1;
			hold_len    <= LEN_DEFAULT;
		end else begin
			wb_ack      <= bus_access;
			// first cycle out of reset, or a restart write on its ack edge
			chain_start <= por_pending || restart_wr;
			por_pending <= 1'b0;
			if (bus_write && (wb_adr == REG_LEN)) begin
				hold_len <= wb_wdata[$bits(step_len_t)-1:0];
			end
		end
	end

	// read data, sampled on the same edge that raises ack
	always_ff @(posedge hw) begin
		if (bus_read) begin
			wb_rdata <= rd_mux;
		end
	end

	// A ctrl write with the restart bit clear still gets its ack,
	// it only has no effect on the chain.
	// A length written during a hold takes effect at the next start,
	// since each step loads its counter only when it starts.

endmodule

// File: hdl/reset_seq_pkg.sv
package reset_seq_pkg;

	// reset hold length, counted in hw cycles
	typedef logic [15:0] step_len_t;

	// wishbone word address and data
	typedef logic [1:0]  wb_addr_t;
	typedef logic [31:0] wb_data_t;

	// one step of the chain
	typedef enum logic [1:0] {
		IDLE,        // not reached yet, or cleared by a restart
		HOLD,        // block held in reset
		WAIT_READY,  // reset released, block still coming up
		DONE         // block reported ready
	} step_state_t;

	// hold length after power-on
	localparam step_len_t LEN_DEFAULT = 16'd20;

	// register map, word addresses
	localparam wb_addr_t REG_CTRL   = 2'd0;  // write only
	localparam wb_addr_t REG_LEN    = 2'd1;  // read and write
	localparam wb_addr_t REG_STATUS = 2'd2;  // done vector, read only

	// REG_CTRL bit that restarts the chain
	localparam int CTRL_RESTART_BIT = 0;

endpackage

// File: hdl/reset_seq_top.sv
`timescale 1ns/1ns

module reset_seq_top #(
	parameter int NSTEP = 4
) (
	input  logic                    hw,
	input  logic                    poweronreset,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  reset_seq_pkg::wb_addr_t wb_adr,
	input  reset_seq_pkg::wb_data_t wb_wdata,
	output reset_seq_pkg::wb_data_t wb_rdata,
	output logic                    wb_ack,
	input  logic [NSTEP-1:0]        step_ready,
	output logic [NSTEP-1:0]        step_reset
);
	import reset_seq_pkg::*;

	logic             chain_start;  // one cycle pulse into step 0
	step_len_t        hold_len;
	logic [NSTEP-1:0] step_done;    // back to the status register

	reset_regs #(
		.NSTEP (NSTEP)
	) u_reset_regs (
		.hw           (hw),
		.poweronreset (poweronreset),
		.wb_cyc       (wb_cyc),
		.wb_stb       (wb_stb),
		.wb_we        (wb_we),
		.wb_adr       (wb_adr),
		.wb_wdata     (wb_wdata),
		.wb_rdata     (wb_rdata),
		.wb_ack       (wb_ack),
		.step_done    (step_done),
		.chain_start  (chain_start),
		.hold_len     (hold_len)
	);

	reset_chain #(
		.NSTEP (NSTEP)
	) u_reset_chain (
		.hw           (hw),
		.poweronreset (poweronreset),
		.chain_start  (chain_start),
		.hold_len     (hold_len),
		.step_ready   (step_ready),
		.step_reset   (step_reset),
		.step_done    (step_done)
	);

endmodule

// File: hdl/reset_step.sv
`timescale 1ns/1ns

module reset_step (
	input  logic                     hw,
	input  logic                     poweronreset,
	input  logic                     start,
	input  reset_seq_pkg::step_len_t hold_len,
	input  logic                     ready,
	output logic                     block_reset,
	output logic                     done,
	output logic                     done_strobe
);
	import reset_seq_pkg::*;

	step_state_t state;
	step_len_t   hold_cnt;    // reset cycles still to go, counting the current one
	logic        hold_last;
	logic        ready_seen;

	// a length of zero behaves like one
	assign hold_last  = (hold_cnt <= step_len_t'(1));
	assign ready_seen = (state == WAIT_READY) && ready;

	// the block sees reset for as long as the step is in HOLD
	assign block_reset = (state == HOLD);
	assign done        = (state == DONE);

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			state       <= IDLE;
			hold_cnt    <= '0;
			done_strobe <= 1'b0;
		end else if (start) begin
			// start wins from any state, also mid hold or mid wait
			state       <= HOLD;
			hold_cnt    <= hold_len;
			done_strobe <= 1'b0;
		end else begin
			done_strobe <= ready_seen;  // one cycle, next step starts from it
			case (state)
				IDLE: begin
					state <= IDLE;
				end
				HOLD: begin
					if (hold_last) begin
						state <= WAIT_READY;
					end else begin
						hold_cnt <= hold_cnt - step_len_t'(1);
					end
				end
				WAIT_READY: begin
					// any latency here, the block decides
					if (ready) begin
						state <= DONE;
					end
				end
				DONE: begin
					state <= DONE;  // stays until the next start or clear
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Timing for a start seen at edge t with hold_len = n:
	// state is HOLD from edge t+1, the counter is n there, and each
	// edge in HOLD either counts down or leaves. The step leaves HOLD
	// at edge t+n+1, so block_reset is high for exactly n cycles.
	// The ready check starts on the edge after that.

endmodule

// File: run.sh
#!/bin/sh
# compile and run the reset sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal --top-module reset_seq_tb -Mdir "$OBJ" -f build.f
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

"./$OBJ/Vreset_seq_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
	echo "test failed"
	exit 1
fi
if ! grep -q "NO ERRORS" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "test passed"
exit 0
